// File: src/mempool_pkg.sv
// ******************************************************************
// Fixed at four groups; link wiring relies on 2-bit group-id XOR
// Address is {group id, bank word}, one word per access
// ******************************************************************
`default_nettype none

package mempool_pkg;

  localparam int unsigned NumGroups     = 4;
  localparam int unsigned GroupIdWidth  = 2;
  localparam int unsigned BankWords     = 64;
  localparam int unsigned BankAddrWidth = 6;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned StrbWidth     = DataWidth / 8;
  localparam int unsigned AddrWidth     = GroupIdWidth + BankAddrWidth;

  // Target group id XOR initiator group id
  typedef enum logic [GroupIdWidth-1:0] {
    ROUTE_LOCAL     = 2'd0,
    ROUTE_EAST      = 2'd1,
    ROUTE_NORTH     = 2'd2,
    ROUTE_NORTHEAST = 2'd3
  } route_e;

  // Core port request
  typedef struct packed {
    logic [DataWidth-1:0] wdata;
    logic                 wen;
    logic [StrbWidth-1:0] be;
    logic [AddrWidth-1:0] addr;
  } tcdm_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
  } tcdm_resp_t;

  // Link and bank request, route is the arrival route at the bank's group
  typedef struct packed {
    logic [DataWidth-1:0]     wdata;
    logic                     wen;
    logic [StrbWidth-1:0]     be;
    logic [BankAddrWidth-1:0] addr;
    route_e                   route;
  } bank_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    route_e               route;
  } bank_resp_t;

  // Response return tracking of the one outstanding core request
  typedef enum logic {
    IDLE,
    WAIT
  } ret_state_e;

endpackage

`default_nettype wire

// File: src/tcdm_req_router.sv
// ******************************************************************
// One outstanding request per core port; a new one waits for resp_done_i
// ******************************************************************
`timescale 1ns/100ps
`default_nettype none

module tcdm_req_router
  import mempool_pkg::*;
#(
  parameter logic [GroupIdWidth-1:0] GroupId = '0
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  tcdm_req_t            core_req_i,
  input  logic                 core_req_valid_i,
  output logic                 core_req_ready_o,
  output bank_req_t            route_req_o,
  output logic [NumGroups-1:0] route_valid_o,
  input  logic [NumGroups-1:0] route_ready_i,
  output route_e               issued_route_o,
  output logic                 issue_o,
  input  logic                 resp_done_i
);

  route_e route;
  logic   outstanding_q;

  // Group bits of the address against our own id
  assign route = route_e'(core_req_i.addr[AddrWidth-1 -: GroupIdWidth] ^ GroupId);

  always_comb begin
    route_req_o.wdata = core_req_i.wdata;
    route_req_o.wen   = core_req_i.wen;
    route_req_o.be    = core_req_i.be;
    route_req_o.addr  = core_req_i.addr[BankAddrWidth-1:0];
    route_req_o.route = route;
  end

  // Valid only on the selected route
  always_comb begin
    route_valid_o        = '0;
    route_valid_o[route] = core_req_valid_i && !outstanding_q;
  end

  assign core_req_ready_o = route_ready_i[route] && !outstanding_q;
  assign issue_o          = core_req_valid_i && core_req_ready_o;
  assign issued_route_o   = route;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= 1'b0;
    end else if (issue_o) begin
      outstanding_q <= 1'b1;
    end else if (resp_done_i) begin
      outstanding_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/tcdm_bank_arbiter.sv
// ******************************************************************
// Source index equals arrival route: 0 local, 1 east, 2 north, 3 NE
// ******************************************************************
`timescale 1ns/100ps
`default_nettype none

module tcdm_bank_arbiter
  import mempool_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  bank_req_t [NumGroups-1:0] in_req_i,
  input  logic      [NumGroups-1:0] in_valid_i,
  output logic      [NumGroups-1:0] in_ready_o,
  output bank_req_t                 bank_req_o,
  output logic                      bank_valid_o,
  input  logic                      bank_ready_i
);

  logic [GroupIdWidth-1:0] ptr_q;
  logic [GroupIdWidth-1:0] gnt_idx;
  logic                    found;

  // Walk sources from the pointer, first valid one wins
  // Ready stays high for sources ahead of the winner so idle ports see ready
  always_comb begin
    logic [GroupIdWidth-1:0] idx;
    found      = 1'b0;
    gnt_idx    = ptr_q;
    in_ready_o = '0;
    for (int unsigned k = 0; k < NumGroups; k++) begin
      idx             = ptr_q + GroupIdWidth'(k);
      in_ready_o[idx] = bank_ready_i && !found;
      if (in_valid_i[idx] && !found) begin
        found   = 1'b1;
        gnt_idx = idx;
      end
    end
  end

  // Tag with the granted index so the response finds its way back
  always_comb begin
    bank_req_o       = in_req_i[gnt_idx];
    bank_req_o.route = route_e'(gnt_idx);
  end

  assign bank_valid_o = found;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (bank_valid_o && bank_ready_i) begin
      ptr_q <= gnt_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/tcdm_bank.sv
// ******************************************************************
// Contents undefined after reset; response holds until resp_ready_i
// ******************************************************************
`timescale 1ns/100ps
`default_nettype none

module tcdm_bank
  import mempool_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  bank_req_t  req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output bank_resp_t resp_o,
  output logic       resp_valid_o,
  input  logic       resp_ready_i
);

  logic [DataWidth-1:0] mem_q [BankWords];
  logic [DataWidth-1:0] new_word;
  logic                 req_fire;

  // Accept when the response slot is empty or drains this cycle
  assign req_ready_o = !resp_valid_o || resp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  // Reads leave the word untouched
  always_comb begin
    new_word = mem_q[req_i.addr];
    for (int unsigned b = 0; b < StrbWidth; b++) begin
      if (req_i.wen && req_i.be[b]) begin
        new_word[8*b +: 8] = req_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_i.wen) begin
        mem_q[req_i.addr] <= new_word;
      end
      resp_o.rdata <= new_word;
      resp_o.route <= req_i.route;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
    end else if (req_fire) begin
      resp_valid_o <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/tcdm_resp_return.sv
// ******************************************************************
// Link arrays indexed by route (1 east, 2 north, 3 northeast)
// Core port takes only the response of its own outstanding route
// ******************************************************************
`timescale 1ns/100ps
`default_nettype none

module tcdm_resp_return
  import mempool_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  bank_resp_t                  bank_resp_i,
  input  logic                        bank_resp_valid_i,
  output logic                        bank_resp_ready_o,
  output bank_resp_t [NumGroups-1:1]  link_resp_o,
  output logic       [NumGroups-1:1]  link_resp_valid_o,
  input  logic       [NumGroups-1:1]  link_resp_ready_i,
  input  bank_resp_t [NumGroups-1:1]  link_in_resp_i,
  input  logic       [NumGroups-1:1]  link_in_valid_i,
  output logic       [NumGroups-1:1]  link_in_ready_o,
  input  route_e                      issued_route_i,
  input  logic                        issue_i,
  output tcdm_resp_t                  core_resp_o,
  output logic                        core_resp_valid_o,
  input  logic                        core_resp_ready_i,
  output logic                        resp_done_o
);

  ret_state_e state_q;
  route_e     route_q;
  logic       wait_local;

  assign wait_local = (state_q == WAIT) && (route_q == ROUTE_LOCAL);

  // Bank side, steer by arrival tag
  always_comb begin
    link_resp_o       = {(NumGroups-1){bank_resp_i}};
    link_resp_valid_o = '0;
    if (bank_resp_i.route == ROUTE_LOCAL) begin
      bank_resp_ready_o = wait_local && core_resp_ready_i;
    end else begin
      link_resp_valid_o[bank_resp_i.route] = bank_resp_valid_i;
      bank_resp_ready_o = link_resp_ready_i[bank_resp_i.route];
    end
  end

  // Core side, local bank or the awaited link
  always_comb begin
    core_resp_valid_o = 1'b0;
    core_resp_o.rdata = bank_resp_i.rdata;
    link_in_ready_o   = '0;
    if (state_q == WAIT) begin
      if (route_q == ROUTE_LOCAL) begin
        core_resp_valid_o = bank_resp_valid_i && (bank_resp_i.route == ROUTE_LOCAL);
      end else begin
        core_resp_valid_o        = link_in_valid_i[route_q];
        core_resp_o.rdata        = link_in_resp_i[route_q].rdata;
        link_in_ready_o[route_q] = core_resp_ready_i;
      end
    end
  end

  assign resp_done_o = core_resp_valid_o && core_resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      route_q <= ROUTE_LOCAL;
    end else begin
      case (state_q)
        IDLE: begin
          if (issue_i) begin
            state_q <= WAIT;
            route_q <= issued_route_i;
          end
        end
        WAIT: begin
          if (resp_done_o) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/mempool_group.sv
// ******************************************************************
// Link ports indexed by direction: 1 east, 2 north, 3 northeast
// ******************************************************************
`timescale 1ns/100ps
`default_nettype none

module mempool_group
  import mempool_pkg::*;
#(
  parameter logic [GroupIdWidth-1:0] GroupId = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Core port
  input  tcdm_req_t                  core_req_i,
  input  logic                       core_req_valid_i,
  output logic                       core_req_ready_o,
  output tcdm_resp_t                 core_resp_o,
  output logic                       core_resp_valid_o,
  input  logic                       core_resp_ready_i,
  // Outgoing requests and their responses
  output bank_req_t  [NumGroups-1:1] mst_req_o,
  output logic       [NumGroups-1:1] mst_req_valid_o,
  input  logic       [NumGroups-1:1] mst_req_ready_i,
  input  bank_resp_t [NumGroups-1:1] mst_resp_i,
  input  logic       [NumGroups-1:1] mst_resp_valid_i,
  output logic       [NumGroups-1:1] mst_resp_ready_o,
  // Incoming requests to our bank
  input  bank_req_t  [NumGroups-1:1] slv_req_i,
  input  logic       [NumGroups-1:1] slv_req_valid_i,
  output logic       [NumGroups-1:1] slv_req_ready_o,
  output bank_resp_t [NumGroups-1:1] slv_resp_o,
  output logic       [NumGroups-1:1] slv_resp_valid_o,
  input  logic       [NumGroups-1:1] slv_resp_ready_i
);

  bank_req_t                 routed_req;
  logic      [NumGroups-1:0] route_valid;
  logic      [NumGroups-1:0] route_ready;
  route_e                    issued_route;
  logic                      issue;
  logic                      resp_done;

  bank_req_t [NumGroups-1:0] arb_req;
  logic      [NumGroups-1:0] arb_valid;
  logic      [NumGroups-1:0] arb_ready;

  bank_req_t  bank_req;
  logic       bank_valid;
  logic       bank_ready;
  bank_resp_t bank_resp;
  logic       bank_resp_valid;
  logic       bank_resp_ready;

  // Input side
  tcdm_req_router #(
    .GroupId(GroupId)
  ) i_router (
    .clk_i           (clk_i           ),
    .rst_i           (rst_i           ),
    .core_req_i      (core_req_i      ),
    .core_req_valid_i(core_req_valid_i),
    .core_req_ready_o(core_req_ready_o),
    .route_req_o     (routed_req      ),
    .route_valid_o   (route_valid     ),
    .route_ready_i   (route_ready     ),
    .issued_route_o  (issued_route    ),
    .issue_o         (issue           ),
    .resp_done_i     (resp_done       )
  );

  // Local request at index 0, links at their arrival route
  assign arb_req         = {slv_req_i, routed_req};
  assign arb_valid       = {slv_req_valid_i, route_valid[ROUTE_LOCAL]};
  assign slv_req_ready_o = arb_ready[NumGroups-1:1];
  assign route_ready     = {mst_req_ready_i, arb_ready[ROUTE_LOCAL]};
  assign mst_req_o       = {(NumGroups-1){routed_req}};
  assign mst_req_valid_o = route_valid[NumGroups-1:1];

  tcdm_bank_arbiter i_arbiter (
    .clk_i       (clk_i     ),
    .rst_i       (rst_i     ),
    .in_req_i    (arb_req   ),
    .in_valid_i  (arb_valid ),
    .in_ready_o  (arb_ready ),
    .bank_req_o  (bank_req  ),
    .bank_valid_o(bank_valid),
    .bank_ready_i(bank_ready)
  );

  tcdm_bank i_bank (
    .clk_i       (clk_i          ),
    .rst_i       (rst_i          ),
    .req_i       (bank_req       ),
    .req_valid_i (bank_valid     ),
    .req_ready_o (bank_ready     ),
    .resp_o      (bank_resp      ),
    .resp_valid_o(bank_resp_valid),
    .resp_ready_i(bank_resp_ready)
  );

  // Output side
  tcdm_resp_return i_resp_return (
    .clk_i             (clk_i            ),
    .rst_i             (rst_i            ),
    .bank_resp_i       (bank_resp        ),
    .bank_resp_valid_i (bank_resp_valid  ),
    .bank_resp_ready_o (bank_resp_ready  ),
    .link_resp_o       (slv_resp_o       ),
    .link_resp_valid_o (slv_resp_valid_o ),
    .link_resp_ready_i (slv_resp_ready_i ),
    .link_in_resp_i    (mst_resp_i       ),
    .link_in_valid_i   (mst_resp_valid_i ),
    .link_in_ready_o   (mst_resp_ready_o ),
    .issued_route_i    (issued_route     ),
    .issue_i           (issue            ),
    .core_resp_o       (core_resp_o      ),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_ready_i (core_resp_ready_i),
    .resp_done_o       (resp_done        )
  );

endmodule

`default_nettype wire

// File: src/mempool_cluster.sv
// ******************************************************************
// Four groups, one core port each; links pair groups by id XOR
// ******************************************************************
`timescale 1ns/100ps
`default_nettype none

module mempool_cluster
  import mempool_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  tcdm_req_t  [NumGroups-1:0]  core_req_i,
  input  logic       [NumGroups-1:0]  core_req_valid_i,
  output logic       [NumGroups-1:0]  core_req_ready_o,
  output tcdm_resp_t [NumGroups-1:0]  core_resp_o,
  output logic       [NumGroups-1:0]  core_resp_valid_o,
  input  logic       [NumGroups-1:0]  core_resp_ready_i
);

  // Per group and direction (1 east, 2 north, 3 northeast)
  bank_req_t  [NumGroups-1:0][NumGroups-1:1] mst_req;
  logic       [NumGroups-1:0][NumGroups-1:1] mst_req_valid;
  logic       [NumGroups-1:0][NumGroups-1:1] mst_req_ready;
  bank_resp_t [NumGroups-1:0][NumGroups-1:1] mst_resp;
  logic       [NumGroups-1:0][NumGroups-1:1] mst_resp_valid;
  logic       [NumGroups-1:0][NumGroups-1:1] mst_resp_ready;
  bank_req_t  [NumGroups-1:0][NumGroups-1:1] slv_req;
  logic       [NumGroups-1:0][NumGroups-1:1] slv_req_valid;
  logic       [NumGroups-1:0][NumGroups-1:1] slv_req_ready;
  bank_resp_t [NumGroups-1:0][NumGroups-1:1] slv_resp;
  logic       [NumGroups-1:0][NumGroups-1:1] slv_resp_valid;
  logic       [NumGroups-1:0][NumGroups-1:1] slv_resp_ready;

  for (genvar g = 0; g < NumGroups; g++) begin : gen_groups
    mempool_group #(
      .GroupId(GroupIdWidth'(g))
    ) i_group (
      .clk_i            (clk_i               ),
      .rst_i            (rst_i               ),
      .core_req_i       (core_req_i[g]       ),
      .core_req_valid_i (core_req_valid_i[g] ),
      .core_req_ready_o (core_req_ready_o[g] ),
      .core_resp_o      (core_resp_o[g]      ),
      .core_resp_valid_o(core_resp_valid_o[g]),
      .core_resp_ready_i(core_resp_ready_i[g]),
      .mst_req_o        (mst_req[g]          ),
      .mst_req_valid_o  (mst_req_valid[g]    ),
      .mst_req_ready_i  (mst_req_ready[g]    ),
      .mst_resp_i       (mst_resp[g]         ),
      .mst_resp_valid_i (mst_resp_valid[g]   ),
      .mst_resp_ready_o (mst_resp_ready[g]   ),
      .slv_req_i        (slv_req[g]          ),
      .slv_req_valid_i  (slv_req_valid[g]    ),
      .slv_req_ready_o  (slv_req_ready[g]    ),
      .slv_resp_o       (slv_resp[g]         ),
      .slv_resp_valid_o (slv_resp_valid[g]   ),
      .slv_resp_ready_i (slv_resp_ready[g]   )
    );
  end : gen_groups

  // Master direction d of group ini meets slave direction d of group ini ^ d
  for (genvar ini = 0; ini < NumGroups; ini++) begin : gen_interconnections
    for (genvar d = 1; d < NumGroups; d++) begin : gen_dirs
      assign slv_req[ini ^ d][d]       = mst_req[ini][d];
      assign slv_req_valid[ini ^ d][d] = mst_req_valid[ini][d];
      assign mst_req_ready[ini][d]     = slv_req_ready[ini ^ d][d];

      assign mst_resp[ini ^ d][d]       = slv_resp[ini][d];
      assign mst_resp_valid[ini ^ d][d] = slv_resp_valid[ini][d];
      assign slv_resp_ready[ini][d]     = mst_resp_ready[ini ^ d][d];
    end : gen_dirs
  end : gen_interconnections

endmodule

`default_nettype wire

// File: verif/mempool_cluster_assert.sv
// ******************************************************************
// Bound into every mempool_group; watches its core port only
// ******************************************************************
`timescale 1ns/100ps
`default_nettype none

module mempool_cluster_assert
  import mempool_pkg::*;
(
  input logic       clk_i,
  input logic       rst_i,
  input logic       core_req_valid_i,
  input logic       core_req_ready_i,
  input tcdm_resp_t core_resp_i,
  input logic       core_resp_valid_i,
  input logic       core_resp_ready_i
);

  ret_state_e port_state_q;

  // Mirror of the one outstanding core request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      port_state_q <= IDLE;
    end else if (port_state_q == IDLE && core_req_valid_i && core_req_ready_i) begin
      port_state_q <= WAIT;
    end else if (port_state_q == WAIT && core_resp_valid_i && core_resp_ready_i) begin
      port_state_q <= IDLE;
    end
  end

  resp_held_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    core_resp_valid_i && !core_resp_ready_i |=> core_resp_valid_i && $stable(core_resp_i))
    else $error("Core response changed or dropped while held");

  no_ready_while_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    port_state_q == WAIT |-> !core_req_ready_i)
    else $error("Core request ready while a request is outstanding");

  no_resp_without_request: assert property (@(posedge clk_i) disable iff (rst_i)
    core_resp_valid_i |-> port_state_q == WAIT)
    else $error("Core response without a pending request");

endmodule

bind mempool_group mempool_cluster_assert i_assert (
  .clk_i            (clk_i            ),
  .rst_i            (rst_i            ),
  .core_req_valid_i (core_req_valid_i ),
  .core_req_ready_i (core_req_ready_o ),
  .core_resp_i      (core_resp_o      ),
  .core_resp_valid_i(core_resp_valid_o),
  .core_resp_ready_i(core_resp_ready_i)
);

`default_nettype wire

// File: verif/tb_mempool_cluster.sv
// ******************************************************************
// Table-driven, one request per port in flight; words read after a full write
// ******************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_mempool_cluster
  import mempool_pkg::*;
();

  localparam int ResetCycles  = 10;
  localparam int CyclesPerVec = 20;

  typedef struct packed {
    logic [7:0]           batch;
    logic [1:0]           port;
    logic                 stall;
    tcdm_req_t            req;
    logic [DataWidth-1:0] exp_rdata;
  } vec_t;

  logic                       clk_i;
  logic                       rst_i;
  tcdm_req_t  [NumGroups-1:0] core_req_i;
  logic       [NumGroups-1:0] core_req_valid_i;
  logic       [NumGroups-1:0] core_req_ready_o;
  tcdm_resp_t [NumGroups-1:0] core_resp_o;
  logic       [NumGroups-1:0] core_resp_valid_o;
  logic       [NumGroups-1:0] core_resp_ready_i;

  vec_t                 vecs [$];
  string                vec_names [$];
  logic [DataWidth-1:0] shadow [NumGroups][BankWords];
  logic [7:0]           cur_batch = '0;
  logic                 cur_stall = 1'b0;
  int                   cycle_count = 0;
  int                   timeout_limit = 0;

  mempool_cluster dut_i (
    .clk_i            (clk_i            ),
    .rst_i            (rst_i            ),
    .core_req_i       (core_req_i       ),
    .core_req_valid_i (core_req_valid_i ),
    .core_req_ready_o (core_req_ready_o ),
    .core_resp_o      (core_resp_o      ),
    .core_resp_valid_o(core_resp_valid_o),
    .core_resp_ready_i(core_resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_error(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "Run stopped at the first error");
  endtask

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    assert (cycle_count <= timeout_limit) else
      report_error($sformatf("Timeout after %0d cycles, a response never arrived", cycle_count));
  end

  // Entries sharing a batch number go out together on different ports
  task automatic new_batch(input logic stall);
    cur_batch = cur_batch + 8'd1;
    cur_stall = stall;
  endtask

  // Shadow memory gives the expected word after each access
  task automatic add_vec(input string name, input int port, input logic wen, input int grp,
                         input int word, input logic [StrbWidth-1:0] be,
                         input logic [DataWidth-1:0] wdata);
    vec_t                 v;
    logic [DataWidth-1:0] w;
    v.batch     = cur_batch;
    v.port      = 2'(port);
    v.stall     = cur_stall;
    v.req.wdata = wdata;
    v.req.wen   = wen;
    v.req.be    = be;
    v.req.addr  = {GroupIdWidth'(grp), BankAddrWidth'(word)};
    w = shadow[v.req.addr[AddrWidth-1 -: GroupIdWidth]][v.req.addr[BankAddrWidth-1:0]];
    for (int b = 0; b < StrbWidth; b++) begin
      if (wen && be[b]) begin
        w[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    shadow[v.req.addr[AddrWidth-1 -: GroupIdWidth]][v.req.addr[BankAddrWidth-1:0]] = w;
    v.exp_rdata = w;
    vecs.push_back(v);
    vec_names.push_back(name);
  endtask

  task automatic build_table();
    int q;
    // Local access, all groups at once
    new_batch(1'b0);
    for (int g = 0; g < NumGroups; g++) begin
      add_vec($sformatf("local_wr_g%0d", g), g, 1'b1, g, 4, 4'hf,
              32'h1234_5678 ^ (32'h1111_1111 * g));
    end
    new_batch(1'b0);
    for (int g = 0; g < NumGroups; g++) begin
      add_vec($sformatf("local_partial_wr_g%0d", g), g, 1'b1, g, 4, 4'b0101, 32'hFFEE_DDCC + g);
    end
    new_batch(1'b0);
    for (int g = 0; g < NumGroups; g++) begin
      add_vec($sformatf("local_rd_g%0d", g), g, 1'b0, g, 4, 4'h0, '0);
    end
    // Port 0 over the east, north and northeast links
    for (int t = 1; t < NumGroups; t++) begin
      new_batch(1'b0);
      add_vec($sformatf("remote_wr_g%0d", t), 0, 1'b1, t, 10, 4'hf, 32'h0BAD_F00D + 32'h1000 * t);
    end
    new_batch(1'b0);
    add_vec("remote_partial_wr_g3", 0, 1'b1, 3, 10, 4'b1100, 32'h5566_7788);
    for (int t = 1; t < NumGroups; t++) begin
      new_batch(1'b0);
      add_vec($sformatf("remote_rd_g%0d", t), 0, 1'b0, t, 10, 4'h0, '0);
    end
    new_batch(1'b0);
    add_vec("rd_g1_from_p3_north", 3, 1'b0, 1, 10, 4'h0, '0);
    add_vec("rd_g3_from_p2_east", 2, 1'b0, 3, 10, 4'h0, '0);
    add_vec("rd_g2_from_p1_northeast", 1, 1'b0, 2, 10, 4'h0, '0);
    // Four ports on bank 2
    new_batch(1'b0);
    for (int p = 0; p < NumGroups; p++) begin
      add_vec($sformatf("contend_wr_p%0d", p), p, 1'b1, 2, 20 + p, 4'hf,
              32'h00C0_FFEE + 32'h0100_0001 * p);
    end
    new_batch(1'b0);
    for (int p = 0; p < NumGroups; p++) begin
      add_vec($sformatf("contend_rd_p%0d", p), p, 1'b0, 2, 20 + (p + 1) % 4, 4'h0, '0);
    end
    // Random response stalls from here on
    new_batch(1'b1);
    for (int p = 0; p < NumGroups; p++) begin
      add_vec($sformatf("stall_wr_p%0d", p), p, 1'b1, p ^ 3, 30 + p, 4'hf,
              32'hA5A5_0000 | (32'h0000_0101 * p));
    end
    new_batch(1'b1);
    for (int p = 0; p < NumGroups; p++) begin
      add_vec($sformatf("stall_partial_wr_p%0d", p), p, 1'b1, p ^ 3, 30 + p, 4'b0011,
              32'h0000_BEE0 + p);
    end
    for (int r = 0; r < 3; r++) begin
      new_batch(1'b1);
      for (int p = 0; p < NumGroups; p++) begin
        q = (p + 1) % 4;
        add_vec($sformatf("stall_rd_r%0d_p%0d", r, p), p, 1'b0, q ^ 3, 30 + q, 4'h0, '0);
      end
      new_batch(1'b1);
      for (int p = 0; p < NumGroups; p++) begin
        add_vec($sformatf("stall_contend_rd_r%0d_p%0d", r, p), p, 1'b0, 2, 20 + p, 4'h0, '0);
      end
    end
  endtask

  task automatic check_response(input int i, input logic [DataWidth-1:0] rdata,
                                input int cycles, input logic stall);
    assert (rdata == vecs[i].exp_rdata) else
      report_error($sformatf("MISMATCH %s: expected %08h, actual %08h",
                             vec_names[i], vecs[i].exp_rdata, rdata));
    // Without stalls each port gets a bank slot within one round of four grants
    assert (stall || cycles <= int'(NumGroups) + 1) else
      report_error($sformatf("Request %s waited %0d cycles, longer than one arbitration round",
                             vec_names[i], cycles));
  endtask

  task automatic run_batch(input int first, input int last);
    logic [NumGroups-1:0] req_pend;
    logic [NumGroups-1:0] wait_resp;
    logic [NumGroups-1:0] held;
    tcdm_resp_t           held_resp [NumGroups];
    int                   idx [NumGroups];
    int                   cycles [NumGroups];
    logic [1:0]           p;
    logic                 stall;
    req_pend  = '0;
    wait_resp = '0;
    held      = '0;
    stall     = vecs[first].stall;
    for (int i = first; i <= last; i++) begin
      p                   = vecs[i].port;
      idx[p]              = i;
      cycles[p]           = 0;
      core_req_i[p]       = vecs[i].req;
      core_req_valid_i[p] = 1'b1;
      req_pend[p]         = 1'b1;
    end
    while ((req_pend | wait_resp) != '0) begin
      // Mid-cycle sample, inputs only move 2 ns after the rising edge
      @(negedge clk_i);
      for (int k = 0; k < NumGroups; k++) begin
        p = 2'(k);
        if (req_pend[p] || wait_resp[p]) begin
          cycles[p]++;
        end
        if (held[p]) begin
          assert (core_resp_valid_o[p]) else
            report_error($sformatf("Port %0d dropped its response before it was taken", p));
          assert (core_resp_o[p] == held_resp[p]) else
            report_error($sformatf("MISMATCH %s held response: expected %08h, actual %08h",
                                   vec_names[idx[p]], held_resp[p].rdata, core_resp_o[p].rdata));
        end
        if (wait_resp[p]) begin
          assert (!core_req_ready_o[p]) else
            report_error($sformatf("Port %0d is ready while a request is outstanding", p));
          held[p]      = core_resp_valid_o[p] && !core_resp_ready_i[p];
          held_resp[p] = core_resp_o[p];
          if (core_resp_valid_o[p] && core_resp_ready_i[p]) begin
            check_response(idx[p], core_resp_o[p].rdata, cycles[p], stall);
            wait_resp[p] = 1'b0;
          end
        end
        if (req_pend[p] && core_req_ready_o[p]) begin
          req_pend[p]  = 1'b0;
          wait_resp[p] = 1'b1;
        end
      end
      @(posedge clk_i);
      #2;
      for (int k = 0; k < NumGroups; k++) begin
        p = 2'(k);
        if (!req_pend[p]) begin
          core_req_valid_i[p] = 1'b0;
        end
        core_resp_ready_i[p] = stall ? (($urandom % 4) != 0) : 1'b1;
      end
    end
    core_resp_ready_i = '1;
  endtask

  initial begin
    int first;
    int last;
    void'($urandom(32'h524a));
    rst_i             = 1'b1;
    core_req_i        = '0;
    core_req_valid_i  = '0;
    core_resp_ready_i = '1;
    build_table();
    timeout_limit = vecs.size() * CyclesPerVec + ResetCycles;
    repeat (ResetCycles) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    @(negedge clk_i);
    assert (core_resp_valid_o == '0) else
      report_error("A core response is valid right after reset");
    assert (core_req_ready_o == '1) else
      report_error("A core request port is not ready right after reset");
    @(posedge clk_i);
    #2;
    first = 0;
    while (first < vecs.size()) begin
      last = first;
      while (last + 1 < vecs.size() && vecs[last + 1].batch == vecs[first].batch) begin
        last++;
      end
      run_batch(first, last);
      first = last + 1;
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
src/mempool_pkg.sv
src/tcdm_req_router.sv
src/tcdm_bank_arbiter.sv
src/tcdm_bank.sv
src/tcdm_resp_return.sv
src/mempool_group.sv
src/mempool_cluster.sv
verif/mempool_cluster_assert.sv
verif/tb_mempool_cluster.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_mempool_cluster
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
